// ==== bench/ps2_mouse_model.sv ====
`timescale 1ns/1ps

module ps2_mouse_model (
	input  logic clk,
	input  logic ps2_clk,
	input  logic ps2_data,
	input  logic host_ready,
	output logic clk_pull,
	output logic data_pull,
	output logic done,
	output int   errors
);

	import ps2_pkg::*;

	localparam int HALF_PERIOD   = 20;
	localparam int RTS_TIMEOUT   = POWERUP_CYCLES + 4 * INHIBIT_CYCLES;
	localparam int READY_TIMEOUT = 2000;

	// Expected packets in the order the scoreboard reads them
	mouse_packet_t exp_pkts [0:63];
	int            exp_cnt;
	integer        seed;
	logic [31:0]   rnd;
	int            n;

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	////////////////////////////////////////
	// Device to host
	////////////////////////////////////////

	// Start, eight data bits LSB first, odd parity, stop
	task automatic send_frame(input logic [7:0] b, input logic bad_parity);
		logic [10:0] frame;
		int          i;
		frame = {1'b1, ~(^b) ^ bad_parity, b, 1'b0};
		for (i = 0; i < 11; i++)
		begin
			data_pull <= ~frame[i];
			wait_cycles(HALF_PERIOD);
			clk_pull <= 1'b1;
			wait_cycles(HALF_PERIOD);
			clk_pull <= 1'b0;
		end
		data_pull <= 1'b0;
		wait_cycles(3 * HALF_PERIOD);
	endtask

	task automatic send_packet(input logic [7:0] st, input logic [7:0] dx, input logic [7:0] dy);
		exp_pkts[exp_cnt] = {st, dx, dy};
		exp_cnt++;
		send_frame(st, 1'b0);
		send_frame(dx, 1'b0);
		send_frame(dy, 1'b0);
	endtask

	////////////////////////////////////////
	// Host to device
	////////////////////////////////////////

	task automatic recv_cmd(input logic [7:0] want, input logic nak);
		logic [9:0] bits;
		int         i;
		int         t;
		t = 0;
		// Request to send is clock released with data held low
		while (!(ps2_clk && !ps2_data) && t < RTS_TIMEOUT)
		begin
			@(posedge clk);
			t++;
		end
		if (t >= RTS_TIMEOUT)
		begin
			errors++;
			$display("mouse model: host never requested to send while %h was due", want);
		end
		else
		begin
			wait_cycles(10);
			// Host changes data after each fall and the bit is sampled just before the rise
			for (i = 0; i < 10; i++)
			begin
				clk_pull <= 1'b1;
				wait_cycles(HALF_PERIOD);
				bits[i] = ps2_data;
				clk_pull <= 1'b0;
				wait_cycles(HALF_PERIOD);
			end
			// Ack driven low or left high to refuse the command
			data_pull <= ~nak;
			wait_cycles(5);
			clk_pull <= 1'b1;
			wait_cycles(HALF_PERIOD);
			clk_pull  <= 1'b0;
			data_pull <= 1'b0;
			wait_cycles(3 * HALF_PERIOD);
			if (!(^bits[8:0]) || !bits[9])
			begin
				errors++;
				$display("mouse model: host frame %h has bad parity or stop bit", bits[7:0]);
			end
			if (bits[7:0] != want)
			begin
				errors++;
				$display("mouse model: host sent command %h while %h was due", bits[7:0], want);
			end
		end
	endtask

	task automatic answer_reset();
		recv_cmd(CMD_RESET, 1'b0);
		send_frame(RESP_ACK, 1'b0);
		send_frame(RESP_BAT_OK, 1'b0);
		send_frame(RESP_ID, 1'b0);
	endtask

	task automatic wait_ready(input logic level);
		int t;
		t = 0;
		while (host_ready != level && t < READY_TIMEOUT)
		begin
			@(posedge clk);
			t++;
		end
		if (host_ready != level)
		begin
			errors++;
			$display("mouse model: host ready did not go to %0d in time", level);
		end
	endtask

	////////////////////////////////////////
	// Scenario script
	////////////////////////////////////////

	initial
	begin
		clk_pull  = 1'b0;
		data_pull = 1'b0;
		done      = 1'b0;
		errors    = 0;
		exp_cnt   = 0;
		seed      = 32'h9af1ed85;
		wait_cycles(20);

		// Clean power-up sequence
		answer_reset();
		recv_cmd(CMD_ENABLE, 1'b0);
		send_frame(RESP_ACK, 1'b0);
		wait_ready(1'b1);

		// Each button, then each sign bit
		send_packet(8'h09, 8'h05, 8'h03);
		send_packet(8'h0A, 8'h12, 8'h07);
		send_packet(8'h0C, 8'h01, 8'h20);
		send_packet(8'h18, 8'hF0, 8'h04);
		send_packet(8'h28, 8'h06, 8'hE0);

		for (n = 0; n < 12; n++)
		begin
			rnd = $random(seed);
			send_packet({2'b00, rnd[9:8], 1'b1, rnd[2:0]}, rnd[31:24], rnd[23:16]);
		end

		// Right and top edges, then left and bottom
		repeat (3) send_packet(8'h08, 8'hFF, 8'hFF);
		repeat (3) send_packet(8'h38, 8'h00, 8'h00);

		// x overflow then y overflow
		send_packet(8'h48, 8'h40, 8'h10);
		send_packet(8'h88, 8'h20, 8'h30);

		// Stray byte without the sync bit
		send_frame(8'h01, 1'b0);
		send_packet(8'h09, 8'h11, 8'h22);

		// Broken packet with bad parity on dx
		send_frame(8'h09, 1'b0);
		send_frame(8'h10, 1'b1);
		send_frame(8'h05, 1'b0);
		wait_ready(1'b0);

		// Restart with a refused enable and a wrong answer
		answer_reset();
		recv_cmd(CMD_ENABLE, 1'b1);
		recv_cmd(CMD_ENABLE, 1'b0);
		send_frame(8'hFE, 1'b0);
		recv_cmd(CMD_ENABLE, 1'b0);
		send_frame(RESP_ACK, 1'b0);
		wait_ready(1'b1);

		send_packet(8'h0B, 8'h07, 8'h09);
		wait_cycles(100);
		done = 1'b1;
	end

endmodule

// ==== bench/tb_ps2_mouse.sv ====
`timescale 1ns/1ps

module tb_ps2_mouse;

	import ps2_pkg::*;

	localparam int RUN_TIMEOUT = 1000000;

	logic          clk;
	logic          reset;
	logic          host_clk_low;
	logic          host_data_low;
	logic          dev_clk_low;
	logic          dev_data_low;
	logic          ps2_clk;
	logic          ps2_data;
	logic          ready;
	mouse_packet_t pkt;
	logic          pkt_valid;
	cursor_t       cursor;
	logic          cursor_valid;
	logic          model_done;
	int            model_errors;
	int            errors;
	int            pkt_seen;
	cursor_t       ref_cur;
	int            t;

	// Pulled-up open-drain lines
	assign ps2_clk  = ~(host_clk_low | dev_clk_low);
	assign ps2_data = ~(host_data_low | dev_data_low);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	ps2_mouse_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.ps2_clk_in   (ps2_clk),
		.ps2_data_in  (ps2_data),
		.ps2_clk_low  (host_clk_low),
		.ps2_data_low (host_data_low),
		.ready        (ready),
		.pkt          (pkt),
		.pkt_valid    (pkt_valid),
		.cursor       (cursor),
		.cursor_valid (cursor_valid)
	);

	ps2_mouse_model model0 (
		.clk        (clk),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.host_ready (ready),
		.clk_pull   (dev_clk_low),
		.data_pull  (dev_data_low),
		.done       (model_done),
		.errors     (model_errors)
	);

	////////////////////////////////////////
	// Reference cursor
	////////////////////////////////////////

	function automatic cursor_t next_cursor(input cursor_t c, input mouse_packet_t p);
		int      dx;
		int      dy;
		int      nx;
		int      ny;
		cursor_t r;
		dx = p.status.x_sign ? int'(p.dx) - 256 : int'(p.dx);
		dy = p.status.y_sign ? int'(p.dy) - 256 : int'(p.dy);
		nx = int'(c.x) + dx;
		// Screen y runs downward
		ny = int'(c.y) - dy;
		if (nx < 0)
			nx = 0;
		if (nx > SCREEN_W - 1)
			nx = SCREEN_W - 1;
		if (ny < 0)
			ny = 0;
		if (ny > SCREEN_H - 1)
			ny = SCREEN_H - 1;
		r = c;
		if (!p.status.x_ovf)
			r.x = 10'(nx);
		if (!p.status.y_ovf)
			r.y = 10'(ny);
		r.buttons = {p.status.middle, p.status.right, p.status.left};
		return r;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			ref_cur  <= '{x: 10'(SCREEN_W / 2), y: 10'(SCREEN_H / 2), buttons: 3'b000};
			pkt_seen <= 0;
		end
		else if (pkt_valid)
		begin
			ref_cur  <= next_cursor(ref_cur, pkt);
			pkt_seen <= pkt_seen + 1;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	pkt_matches: assert property (
		@(posedge clk) disable iff (reset)
		pkt_valid |-> (pkt_seen < model0.exp_cnt && pkt == model0.exp_pkts[pkt_seen])
	) else
	begin
		errors++;
		$display("error: packet_decode expected %h actual %h",
			model0.exp_pkts[$sampled(pkt_seen)], $sampled(pkt));
	end

	cursor_matches: assert property (
		@(posedge clk) disable iff (reset)
		cursor_valid |-> cursor == ref_cur
	) else
	begin
		errors++;
		$display("error: cursor_track expected x=%0d y=%0d btn=%b actual x=%0d y=%0d btn=%b",
			ref_cur.x, ref_cur.y, ref_cur.buttons, cursor.x, cursor.y, cursor.buttons);
	end

	// Tracker answers one cycle after each packet
	cursor_follows_pkt: assert property (
		@(posedge clk) disable iff (reset)
		pkt_valid |=> cursor_valid
	) else
	begin
		errors++;
		$display("error: cursor_latency expected 1 actual %b", $sampled(cursor_valid));
	end

	initial
	begin
		errors = 0;
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		t = 0;
		while (!model_done && t < RUN_TIMEOUT)
		begin
			@(posedge clk);
			t++;
		end
		if (!model_done)
		begin
			errors++;
			$display("scenario did not finish within %0d cycles", RUN_TIMEOUT);
		end
		if (pkt_seen != model0.exp_cnt)
		begin
			errors++;
			$display("error: packet_count expected %0d actual %0d", model0.exp_cnt, pkt_seen);
		end
		$display("check errors %0d, bus protocol errors %0d", errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
hw/ps2_pkg.sv
hw/ps2_rx.sv
hw/ps2_tx.sv
hw/mouse_ctrl.sv
hw/mouse_track.sv
hw/ps2_mouse_top.sv
bench/ps2_mouse_model.sv
bench/tb_ps2_mouse.sv

// ==== hw/mouse_ctrl.sv ====
`timescale 1ns/1ps

module mouse_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  ps2_pkg::rx_byte_t      rx_byte,
	input  logic                   rx_valid,
	input  logic                   tx_busy,
	input  logic                   tx_done,
	input  logic                   tx_nak,
	output logic                   tx_start,
	output logic [7:0]             tx_cmd,
	output ps2_pkg::mouse_packet_t pkt,
	output logic                   pkt_valid,
	output logic                   ready
);

	import ps2_pkg::*;

	logic [3:0]         state;
	logic [TIMER_W-1:0] cnt;
	logic [1:0]         byte_idx;
	mouse_status_t      status_buf;
	logic [7:0]         dx_buf;
	mouse_status_t      rx_status;
	logic               rx_err;
	logic               watchdog_hit;
	logic [7:0]         exp_byte;
	logic [3:0]         pass_state;
	logic [3:0]         fail_state;

	assign rx_err       = rx_byte.parity_err | rx_byte.frame_err;
	assign rx_status    = mouse_status_t'(rx_byte.data);
	assign watchdog_hit = cnt == TIMER_W'(WATCHDOG_CYCLES - 1);

	assign tx_start = (state == ST_SEND_RST || state == ST_SEND_EN) && !tx_busy;
	assign tx_cmd   = (state == ST_SEND_EN) ? CMD_ENABLE : CMD_RESET;
	assign ready    = state == ST_STREAM;

	// Expected response per wait state
	always_comb
	begin
		exp_byte   = RESP_ACK;
		pass_state = ST_PWRUP;
		fail_state = ST_PWRUP;
		case (state)
			ST_EXP_ACK:
				pass_state = ST_EXP_BAT;
			ST_EXP_BAT:
			begin
				exp_byte   = RESP_BAT_OK;
				pass_state = ST_EXP_ID;
			end
			ST_EXP_ID:
			begin
				exp_byte   = RESP_ID;
				pass_state = ST_SEND_EN;
			end
			ST_EXP_EN_ACK:
			begin
				pass_state = ST_STREAM;
				fail_state = ST_SEND_EN;
			end
			default:
				pass_state = ST_PWRUP;
		endcase
	end

	////////////////////////////////////////
	// Init and streaming FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= ST_PWRUP;
			cnt       <= '0;
			byte_idx  <= '0;
			pkt_valid <= 1'b0;
		end
		else
		begin
			pkt_valid <= 1'b0;
			case (state)
				ST_PWRUP:
				begin
					if (cnt == TIMER_W'(POWERUP_CYCLES - 1))
					begin
						cnt   <= '0;
						state <= ST_SEND_RST;
					end
					else
						cnt <= cnt + 1'b1;
				end

				ST_SEND_RST:
					if (tx_start)
						state <= ST_WAIT_RST;

				ST_WAIT_RST:
				begin
					if (tx_done)
					begin
						cnt   <= '0;
						state <= tx_nak ? ST_PWRUP : ST_EXP_ACK;
					end
				end

				ST_SEND_EN:
					if (tx_start)
						state <= ST_WAIT_EN;

				// NAK on enable goes straight back to resending it
				ST_WAIT_EN:
				begin
					if (tx_done)
					begin
						cnt   <= '0;
						state <= tx_nak ? ST_SEND_EN : ST_EXP_EN_ACK;
					end
				end

				ST_EXP_ACK, ST_EXP_BAT, ST_EXP_ID, ST_EXP_EN_ACK:
				begin
					if (rx_valid)
					begin
						cnt      <= '0;
						byte_idx <= '0;
						if (rx_err)
							state <= ST_PWRUP;
						else if (rx_byte.data == exp_byte)
							state <= pass_state;
						else
							state <= fail_state;
					end
					else if (watchdog_hit)
					begin
						cnt   <= '0;
						state <= ST_PWRUP;
					end
					else
						cnt <= cnt + 1'b1;
				end

				ST_STREAM:
				begin
					if (rx_valid && rx_err)
					begin
						cnt      <= '0;
						byte_idx <= '0;
						state    <= ST_PWRUP;
					end
					else if (rx_valid)
					begin
						case (byte_idx)
							2'd0:
							begin
								// Out of step bytes fail the sync check and are dropped
								if (rx_status.sync_one)
								begin
									status_buf <= rx_status;
									byte_idx   <= 2'd1;
								end
							end
							2'd1:
							begin
								dx_buf   <= rx_byte.data;
								byte_idx <= 2'd2;
							end
							default:
							begin
								pkt       <= '{status: status_buf, dx: dx_buf, dy: rx_byte.data};
								pkt_valid <= 1'b1;
								byte_idx  <= 2'd0;
							end
						endcase
					end
				end

				default:
				begin
					cnt   <= '0;
					state <= ST_PWRUP;
				end
			endcase
		end
	end

endmodule

// ==== hw/mouse_track.sv ====
`timescale 1ns/1ps

module mouse_track (
	input  logic                   clk,
	input  logic                   reset,
	input  ps2_pkg::mouse_packet_t pkt,
	input  logic                   pkt_valid,
	output ps2_pkg::cursor_t       cursor,
	output logic                   cursor_valid
);

	import ps2_pkg::*;

	logic signed [8:0]  dx9;
	logic signed [8:0]  dy9;
	logic signed [11:0] x_sum;
	logic signed [11:0] y_sum;
	logic [9:0]         x_new;
	logic [9:0]         y_new;

	function automatic logic [9:0] clamp_axis(
		input logic signed [11:0] v,
		input logic signed [11:0] hi
	);
		logic [9:0] r;
		if (v < 0)
			r = '0;
		else if (v > hi)
			r = hi[9:0];
		else
			r = v[9:0];
		return r;
	endfunction

	// Nine bit two's complement deltas
	assign dx9 = {pkt.status.x_sign, pkt.dx};
	assign dy9 = {pkt.status.y_sign, pkt.dy};

	// Screen y grows downward, mouse y grows upward
	assign x_sum = $signed({2'b00, cursor.x}) + 12'(dx9);
	assign y_sum = $signed({2'b00, cursor.y}) - 12'(dy9);

	assign x_new = clamp_axis(x_sum, 12'(SCREEN_W - 1));
	assign y_new = clamp_axis(y_sum, 12'(SCREEN_H - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cursor.x       <= 10'(SCREEN_W / 2);
			cursor.y       <= 10'(SCREEN_H / 2);
			cursor.buttons <= '0;
			cursor_valid   <= 1'b0;
		end
		else
		begin
			cursor_valid <= pkt_valid;
			if (pkt_valid)
			begin
				// Overflowed axis holds still
				if (!pkt.status.x_ovf)
					cursor.x <= x_new;
				if (!pkt.status.y_ovf)
					cursor.y <= y_new;
				cursor.buttons <= {pkt.status.middle, pkt.status.right, pkt.status.left};
			end
		end
	end

	cursor_in_bounds: assert property (
		@(posedge clk) disable iff (reset)
		cursor.x < 10'(SCREEN_W) && cursor.y < 10'(SCREEN_H)
	) else $error("mouse_track: cursor left the screen");

endmodule

// ==== hw/ps2_mouse_top.sv ====
`timescale 1ns/1ps

module ps2_mouse_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ps2_clk_in,
	input  logic                   ps2_data_in,
	output logic                   ps2_clk_low,
	output logic                   ps2_data_low,
	output logic                   ready,
	output ps2_pkg::mouse_packet_t pkt,
	output logic                   pkt_valid,
	output ps2_pkg::cursor_t       cursor,
	output logic                   cursor_valid
);

	import ps2_pkg::*;

	rx_byte_t   rx_byte;
	logic       rx_valid;
	logic       tx_start;
	logic [7:0] tx_cmd;
	logic       tx_busy;
	logic       tx_done;
	logic       tx_nak;

	ps2_rx rx0 (
		.clk         (clk),
		.reset       (reset),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.tx_busy     (tx_busy),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid)
	);

	mouse_ctrl ctrl0 (
		.clk       (clk),
		.reset     (reset),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.tx_nak    (tx_nak),
		.tx_start  (tx_start),
		.tx_cmd    (tx_cmd),
		.pkt       (pkt),
		.pkt_valid (pkt_valid),
		.ready     (ready)
	);

	// Only the transmitter pulls the lines
	ps2_tx tx0 (
		.clk          (clk),
		.reset        (reset),
		.tx_start     (tx_start),
		.tx_cmd       (tx_cmd),
		.ps2_clk_in   (ps2_clk_in),
		.ps2_data_in  (ps2_data_in),
		.ps2_clk_low  (ps2_clk_low),
		.ps2_data_low (ps2_data_low),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.tx_nak       (tx_nak)
	);

	mouse_track track0 (
		.clk          (clk),
		.reset        (reset),
		.pkt          (pkt),
		.pkt_valid    (pkt_valid),
		.cursor       (cursor),
		.cursor_valid (cursor_valid)
	);

endmodule

// ==== hw/ps2_pkg.sv ====
package ps2_pkg;

	////////////////////////////////////////
	// Protocol bytes
	////////////////////////////////////////

	localparam logic [7:0] CMD_RESET   = 8'hFF;
	localparam logic [7:0] CMD_ENABLE  = 8'hF4;
	localparam logic [7:0] RESP_ACK    = 8'hFA;
	localparam logic [7:0] RESP_BAT_OK = 8'hAA;
	localparam logic [7:0] RESP_ID     = 8'h00;

	// Timing in clk cycles
	localparam int POWERUP_CYCLES  = 60000;
	localparam int INHIBIT_CYCLES  = 800;
	localparam int WATCHDOG_CYCLES = 200000;

	// Wide enough for the watchdog, the longest count
	localparam int TIMER_W = 18;

	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;

	// Transmitter states
	localparam logic [1:0] TX_IDLE    = 2'd0;
	localparam logic [1:0] TX_INHIBIT = 2'd1;
	localparam logic [1:0] TX_SHIFT   = 2'd2;

	// Controller states
	localparam logic [3:0] ST_PWRUP      = 4'd0;
	localparam logic [3:0] ST_SEND_RST   = 4'd1;
	localparam logic [3:0] ST_WAIT_RST   = 4'd2;
	localparam logic [3:0] ST_EXP_ACK    = 4'd3;
	localparam logic [3:0] ST_EXP_BAT    = 4'd4;
	localparam logic [3:0] ST_EXP_ID     = 4'd5;
	localparam logic [3:0] ST_SEND_EN    = 4'd6;
	localparam logic [3:0] ST_WAIT_EN    = 4'd7;
	localparam logic [3:0] ST_EXP_EN_ACK = 4'd8;
	localparam logic [3:0] ST_STREAM     = 4'd9;

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////

	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		logic       frame_err;
	} rx_byte_t;

	// First byte of a movement packet
	typedef struct packed {
		logic y_ovf;
		logic x_ovf;
		logic y_sign;
		logic x_sign;
		logic sync_one;
		logic middle;
		logic right;
		logic left;
	} mouse_status_t;

	typedef struct packed {
		mouse_status_t status;
		logic [7:0]    dx;
		logic [7:0]    dy;
	} mouse_packet_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic [2:0] buttons;
	} cursor_t;

endpackage

// ==== hw/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx (
	input  logic              clk,
	input  logic              reset,
	input  logic              ps2_clk_in,
	input  logic              ps2_data_in,
	input  logic              tx_busy,
	output ps2_pkg::rx_byte_t rx_byte,
	output logic              rx_valid
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_prev;
	logic       clk_fall;
	logic [9:0] shift;
	logic [3:0] bit_cnt;

	////////////////////////////////////////
	// Line synchronizers
	////////////////////////////////////////

	// Idle lines float high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end
		else
		begin
			clk_sync  <= {clk_sync[0], ps2_clk_in};
			data_sync <= {data_sync[0], ps2_data_in};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	////////////////////////////////////////
	// Frame deserializer
	////////////////////////////////////////

	// Bits arrive LSB first; after ten shifts shift[0] holds the start bit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (tx_busy)
				bit_cnt <= '0;
			else if (clk_fall)
			begin
				if (bit_cnt == 4'd10)
				begin
					bit_cnt  <= '0;
					rx_valid <= 1'b1;
				end
				else
				begin
					shift   <= {data_sync[1], shift[9:1]};
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// Stop bit is still on the synchronized line at the eleventh edge
	always_ff @(posedge clk)
	begin
		if (clk_fall && bit_cnt == 4'd10)
		begin
			rx_byte.data       <= shift[8:1];
			rx_byte.parity_err <= ~(^shift[9:1]);
			rx_byte.frame_err  <= shift[0] | ~data_sync[1];
		end
	end

	// Host transmit owns the bus, so nothing may be delivered meanwhile
	rx_quiet_during_tx: assert property (
		@(posedge clk) disable iff (reset)
		tx_busy |-> !rx_valid
	) else $error("ps2_rx: byte delivered while host transmits");

endmodule

// ==== hw/ps2_tx.sv ====
`timescale 1ns/1ps

module ps2_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_cmd,
	input  logic       ps2_clk_in,
	input  logic       ps2_data_in,
	output logic       ps2_clk_low,
	output logic       ps2_data_low,
	output logic       tx_busy,
	output logic       tx_done,
	output logic       tx_nak
);

	import ps2_pkg::*;

	logic [1:0]         state;
	logic [TIMER_W-1:0] cnt;
	logic [8:0]         bits;
	logic [3:0]         bit_cnt;
	logic [1:0]         clk_sync;
	logic [1:0]         data_sync;
	logic               clk_prev;
	logic               clk_fall;

	// Own synchronizers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end
		else
		begin
			clk_sync  <= {clk_sync[0], ps2_clk_in};
			data_sync <= {data_sync[0], ps2_data_in};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	////////////////////////////////////////
	// Command sequencer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state        <= TX_IDLE;
			cnt          <= '0;
			bit_cnt      <= '0;
			ps2_clk_low  <= 1'b0;
			ps2_data_low <= 1'b0;
			tx_busy      <= 1'b0;
			tx_done      <= 1'b0;
			tx_nak       <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			tx_nak  <= 1'b0;
			case (state)
				TX_IDLE:
				begin
					if (tx_start)
					begin
						// Odd parity bit above the command
						bits        <= {~(^tx_cmd), tx_cmd};
						cnt         <= '0;
						tx_busy     <= 1'b1;
						ps2_clk_low <= 1'b1;
						state       <= TX_INHIBIT;
					end
				end

				TX_INHIBIT:
				begin
					if (cnt == TIMER_W'(INHIBIT_CYCLES - 1))
					begin
						// Request to send: start bit low, clock handed to device
						ps2_clk_low  <= 1'b0;
						ps2_data_low <= 1'b1;
						bit_cnt      <= '0;
						state        <= TX_SHIFT;
					end
					else
						cnt <= cnt + 1'b1;
				end

				TX_SHIFT:
				begin
					if (clk_fall)
					begin
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt < 4'd9)
						begin
							ps2_data_low <= ~bits[0];
							bits         <= {1'b0, bits[8:1]};
						end
						else if (bit_cnt == 4'd9)
							ps2_data_low <= 1'b0;
						else
						begin
							// Device drives ack low on the eleventh clock
							tx_nak  <= data_sync[1];
							tx_done <= 1'b1;
							tx_busy <= 1'b0;
							state   <= TX_IDLE;
						end
					end
				end

				default:
					state <= TX_IDLE;
			endcase
		end
	end

	tx_start_when_idle: assert property (
		@(posedge clk) disable iff (reset)
		tx_start |-> !tx_busy
	) else $error("ps2_tx: command started while a transfer is active");

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ps2_mouse -f compile.f
./obj_dir/Vtb_ps2_mouse > sim.log
cat sim.log

if grep -q "Test FAILED" sim.log
then
	exit 1
fi
